// ==== Makefile ====
# Verilator simulation of the Geiger counter front end

TOP       ?= tb_geiger
SIM_DIR   ?= sim_build
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run $(TOP), then search $(LOG) for a failure"
	@echo "  clean  remove $(SIM_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(SIM_DIR) -f verilog.f
	./$(SIM_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Something failed" $(LOG); then \
	    echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf $(SIM_DIR) $(LOG)

// ==== geiger_apb_pkg.sv ====
`default_nettype none

package geiger_apb_pkg;

    typedef logic [7:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // requester side of the bus
    typedef struct packed
    {
        logic      psel;
        logic      penable;
        logic      pwrite;
        apb_addr_t paddr;
        apb_data_t pwdata;
    } apb_req_t;

    // completer side of the bus
    typedef struct packed
    {
        apb_data_t prdata;
        logic      pready;
        logic      pslverr;
    } apb_rsp_t;

    //--------------------------------------------------
    // register map

    localparam apb_addr_t REG_COUNT    = 8'h00;
    localparam apb_addr_t REG_EXPOSURE = 8'h04;
    localparam apb_addr_t REG_CTRL     = 8'h08;
    localparam apb_addr_t REG_STATUS   = 8'h0C;

    // control register, enable in bit 1 and clear in bit 0
    typedef struct packed
    {
        logic enable;
        logic clear;
    } ctrl_t;

endpackage

`default_nettype wire

// ==== geiger_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module geiger_apb_regs
    import geiger_types_pkg::*;
    import geiger_apb_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  apb_req_t      apb_req,
    output apb_rsp_t      apb_rsp,
    input  particle_cnt_t particle_cnt,
    input  exposure_cnt_t exposure_cnt,
    input  tube_vec_t     tube_ext,
    output logic          count_clear,
    output logic          count_enable
);

    logic      access;
    logic      ctrl_wr;
    logic      mapped;
    ctrl_t     wr_ctrl;
    ctrl_t     rd_ctrl;
    apb_data_t rd_data;

    // second phase of a transfer
    assign access  = apb_req.psel & apb_req.penable;
    assign ctrl_wr = access & apb_req.pwrite & (apb_req.paddr == REG_CTRL);
    assign wr_ctrl = ctrl_t'(apb_req.pwdata[$bits(ctrl_t) - 1:0]);

    //--------------------------------------------------
    // address decode and read mux

    always_comb
    begin
        rd_ctrl        = '0;
        rd_ctrl.enable = count_enable;
        mapped         = 1'b1;
        case (apb_req.paddr)
            REG_COUNT:    rd_data = apb_data_t'(particle_cnt);
            REG_EXPOSURE: rd_data = apb_data_t'(exposure_cnt);
            REG_CTRL:     rd_data = apb_data_t'(rd_ctrl);
            REG_STATUS:   rd_data = apb_data_t'(tube_ext);
            default:
            begin
                rd_data = '0;
                mapped  = 1'b0;
            end
        endcase
    end

    // zero wait states, error only on an unmapped access
    always_comb
    begin
        apb_rsp.prdata  = access ? rd_data : '0;
        apb_rsp.pready  = 1'b1;
        apb_rsp.pslverr = access & ~mapped;
    end

    //--------------------------------------------------
    // control register, clear is a single-cycle pulse

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            count_enable <= 1'b1;
            count_clear  <= 1'b0;
        end
        else
        begin
            count_clear <= 1'b0;
            if (ctrl_wr)
            begin
                count_enable <= wr_ctrl.enable;
                count_clear  <= wr_ctrl.clear;
            end
        end
    end

endmodule

`default_nettype wire

// ==== geiger_config.svh ====
`ifndef GEIGER_CONFIG_SVH
`define GEIGER_CONFIG_SVH

// tube inputs on the shield
`define GEIGER_N_TUBES      2

// pulse stretch in clocks, short for simulation
`define GEIGER_EXT_CYCLES   64

// clocks spent on each display digit
`define GEIGER_SCAN_DIV     16

// counter widths
`define GEIGER_W_PARTICLE   24
`define GEIGER_W_EXPOSURE   16

// multiplexed seven-segment digits
`define GEIGER_N_DIGITS     8

`endif

// ==== geiger_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module geiger_props
    import geiger_types_pkg::*;
    import geiger_apb_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input apb_req_t  apb_req,
    input apb_rsp_t  apb_rsp,
    input tube_vec_t tube_edge
);

    // access phase only directly after a setup phase
    a_setup_before_access: assert property (@(posedge clk) disable iff (rst)
        apb_req.penable |-> apb_req.psel && $past(apb_req.psel && !apb_req.penable))
    else
        $error("penable high without a preceding setup cycle");

    // zero wait states
    a_pready_high: assert property (@(posedge clk) disable iff (rst)
        apb_rsp.pready)
    else
        $error("pready low");

    // edge pulse is a single cycle per tube
    a_edge_single: assert property (@(posedge clk) disable iff (rst)
        (tube_edge & $past(tube_edge)) == '0)
    else
        $error("tube_edge high for two cycles in a row");

endmodule

bind geiger_top geiger_props u_props
(
    .clk       (clk),
    .rst       (rst),
    .apb_req   (apb_req),
    .apb_rsp   (apb_rsp),
    .tube_edge (tube_edge)
);

`default_nettype wire

// ==== geiger_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "geiger_config.svh"

module geiger_top
    import geiger_types_pkg::*;
    import geiger_apb_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  tube_vec_t  tube_raw,
    input  apb_req_t   apb_req,
    output apb_rsp_t   apb_rsp,
    output tube_vec_t  led,
    output segments_t  abcdefgh,
    output digit_sel_t digit
);

    // exposure bits that fit above the particle count
    localparam int w_exp_shown = $bits(display_num_t) - $bits(particle_cnt_t);

    tube_vec_t                     tube_level;
    tube_vec_t                     tube_edge;
    tube_vec_t                     tube_ext;
    logic                          count_clear;
    logic                          count_enable;
    particle_cnt_t                 particle_cnt;
    exposure_cnt_t                 exposure_cnt;
    display_num_t                  display_num;
    logic [`GEIGER_N_DIGITS - 1:0] dots;

    //--------------------------------------------------
    // input side

    tube_pulse_conditioner i_cond
    (
        .clk        (clk),
        .rst        (rst),
        .tube_raw   (tube_raw),
        .tube_level (tube_level),
        .tube_edge  (tube_edge)
    );

    //--------------------------------------------------
    // counting and stretching

    particle_counter i_count
    (
        .clk          (clk),
        .rst          (rst),
        .tube_level   (tube_level),
        .tube_edge    (tube_edge),
        .count_clear  (count_clear),
        .count_enable (count_enable),
        .particle_cnt (particle_cnt),
        .exposure_cnt (exposure_cnt),
        .tube_ext     (tube_ext)
    );

    //--------------------------------------------------
    // output side

    assign display_num = {exposure_cnt[w_exp_shown - 1:0], particle_cnt};
    assign led         = tube_ext;

    // stretched tubes repeat across the decimal points
    always_comb
    begin
        for (int i = 0; i < `GEIGER_N_DIGITS; i++)
            dots[i] = tube_ext[i % `GEIGER_N_TUBES];
    end

    seven_segment_scan i_scan
    (
        .clk         (clk),
        .rst         (rst),
        .display_num (display_num),
        .dots        (dots),
        .abcdefgh    (abcdefgh),
        .digit       (digit)
    );

    geiger_apb_regs i_regs
    (
        .clk          (clk),
        .rst          (rst),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .particle_cnt (particle_cnt),
        .exposure_cnt (exposure_cnt),
        .tube_ext     (tube_ext),
        .count_clear  (count_clear),
        .count_enable (count_enable)
    );

endmodule

`default_nettype wire

// ==== geiger_types_pkg.sv ====
`default_nettype none

`include "geiger_config.svh"

package geiger_types_pkg;

    // one bit per tube, and a count of tubes
    typedef logic [`GEIGER_N_TUBES - 1:0]                  tube_vec_t;
    typedef logic [$clog2(`GEIGER_N_TUBES + 1) - 1:0]      tube_sum_t;

    // counting datapath
    typedef logic [`GEIGER_W_PARTICLE - 1:0]               particle_cnt_t;
    typedef logic [`GEIGER_W_EXPOSURE - 1:0]               exposure_cnt_t;

    // display, four bits per hex digit
    typedef logic [4 * `GEIGER_N_DIGITS - 1:0]             display_num_t;
    typedef logic [7:0]                                    segments_t;
    typedef logic [`GEIGER_N_DIGITS - 1:0]                 digit_sel_t;

    typedef enum logic
    {
        SCAN_IDLE,
        SCAN_RUN
    } scan_state_t;

endpackage

`default_nettype wire

// ==== particle_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "geiger_config.svh"

module particle_counter
    import geiger_types_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  tube_vec_t     tube_level,
    input  tube_vec_t     tube_edge,
    input  logic          count_clear,
    input  logic          count_enable,
    output particle_cnt_t particle_cnt,
    output exposure_cnt_t exposure_cnt,
    output tube_vec_t     tube_ext
);

    localparam int w_ext_cnt = $clog2(`GEIGER_EXT_CYCLES + 1);

    tube_sum_t edge_sum;
    tube_sum_t level_sum;

    // number of tubes firing and number of tubes high this cycle
    always_comb
    begin
        edge_sum  = '0;
        level_sum = '0;
        for (int i = 0; i < `GEIGER_N_TUBES; i++)
        begin
            edge_sum  = edge_sum + tube_sum_t'(tube_edge[i]);
            level_sum = level_sum + tube_sum_t'(tube_level[i]);
        end
    end

    //--------------------------------------------------
    // counters, clear wins over counting

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            particle_cnt <= '0;
            exposure_cnt <= '0;
        end
        else if (count_clear)
        begin
            particle_cnt <= '0;
            exposure_cnt <= '0;
        end
        else if (count_enable)
        begin
            // both wrap
            particle_cnt <= particle_cnt + particle_cnt_t'(edge_sum);
            exposure_cnt <= exposure_cnt + exposure_cnt_t'(level_sum);
        end
    end

    //--------------------------------------------------
    // pulse stretchers, one per tube

    for (genvar t = 0; t < `GEIGER_N_TUBES; t++)
    begin : gen_stretch

        logic [w_ext_cnt - 1:0] ext_cnt;

        always_ff @(posedge clk or posedge rst)
        begin
            if (rst)
                ext_cnt <= '0;
            else if (tube_edge[t])
                ext_cnt <= w_ext_cnt'(`GEIGER_EXT_CYCLES);
            else if (ext_cnt != '0)
                ext_cnt <= ext_cnt - 1'b1;
        end

        assign tube_ext[t] = |ext_cnt;
    end

endmodule

`default_nettype wire

// ==== seven_segment_scan.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "geiger_config.svh"

module seven_segment_scan
    import geiger_types_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst,
    input  display_num_t                 display_num,
    input  logic [`GEIGER_N_DIGITS - 1:0] dots,
    output segments_t                    abcdefgh,
    output digit_sel_t                   digit
);

    localparam int w_idx = $clog2(`GEIGER_N_DIGITS);
    localparam int w_div = $clog2(`GEIGER_SCAN_DIV + 1);

    scan_state_t        state;
    logic [w_div - 1:0] div_cnt;
    logic [w_idx - 1:0] idx;
    logic [3:0]         nibble;
    logic [6:0]         seg_abcdefg;

    //--------------------------------------------------
    // scan FSM, divider and digit index

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state   <= SCAN_IDLE;
            div_cnt <= '0;
            idx     <= '0;
        end
        else
        begin
            case (state)
                SCAN_IDLE:
                begin
                    state   <= SCAN_RUN;
                    div_cnt <= '0;
                    idx     <= '0;
                end
                SCAN_RUN:
                begin
                    if (div_cnt == w_div'(`GEIGER_SCAN_DIV - 1))
                    begin
                        div_cnt <= '0;
                        if (idx == w_idx'(`GEIGER_N_DIGITS - 1))
                            idx <= '0;
                        else
                            idx <= idx + 1'b1;
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                end
                default:
                    state <= SCAN_IDLE;
            endcase
        end
    end

    //--------------------------------------------------
    // hex decoder, segment a is the msb

    assign nibble = display_num[4 * idx +: 4];

    always_comb
    begin
        case (nibble)
            4'h0: seg_abcdefg = 7'b1111110;
            4'h1: seg_abcdefg = 7'b0110000;
            4'h2: seg_abcdefg = 7'b1101101;
            4'h3: seg_abcdefg = 7'b1111001;
            4'h4: seg_abcdefg = 7'b0110011;
            4'h5: seg_abcdefg = 7'b1011011;
            4'h6: seg_abcdefg = 7'b1011111;
            4'h7: seg_abcdefg = 7'b1110000;
            4'h8: seg_abcdefg = 7'b1111111;
            4'h9: seg_abcdefg = 7'b1111011;
            4'ha: seg_abcdefg = 7'b1110111;
            4'hb: seg_abcdefg = 7'b0011111;
            4'hc: seg_abcdefg = 7'b1001110;
            4'hd: seg_abcdefg = 7'b0111101;
            4'he: seg_abcdefg = 7'b1001111;
            default: seg_abcdefg = 7'b1000111;
        endcase
    end

    // registered outputs, digit and pattern always move together
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            abcdefgh <= '0;
            digit    <= '0;
        end
        else
        begin
            abcdefgh <= {seg_abcdefg, dots[idx]};
            digit    <= digit_sel_t'(1) << idx;
        end
    end

endmodule

`default_nettype wire

// ==== tb_geiger.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "geiger_config.svh"

module tb_geiger
    import geiger_types_pkg::*;
    import geiger_apb_pkg::*;
();

    localparam int n_rounds    = 4;
    localparam int n_segs      = 40;
    localparam int n_short     = 10;
    localparam int max_hold    = 8;
    localparam int settle      = 4;
    localparam int ext_wait    = `GEIGER_EXT_CYCLES + 10;
    localparam int scan_cycles = `GEIGER_N_DIGITS * `GEIGER_SCAN_DIV + 32;
    localparam int test_cycles = 10 + n_rounds * (n_segs * max_hold + 20)
                               + 2 * n_short * max_hold + 3 * ext_wait + scan_cycles + 200;
    localparam int watchdog_cycles = test_cycles + test_cycles / 4;

    logic       clk;
    logic       rst;
    tube_vec_t  tube_raw;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    tube_vec_t  led;
    segments_t  abcdefgh;
    digit_sel_t digit;

    // reference model state
    particle_cnt_t m_count;
    exposure_cnt_t m_exposure;
    logic          m_enable;
    tube_vec_t     m_prev_raw;
    int            m_age [`GEIGER_N_TUBES];

    int          errors;
    int          checks;
    int          tests_run;
    logic [31:0] rng_state;

    geiger_top DUT
    (
        .clk      (clk),
        .rst      (rst),
        .tube_raw (tube_raw),
        .apb_req  (apb_req),
        .apb_rsp  (apb_rsp),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    initial
        clk = 1'b0;
    always #5 clk = ~clk;

    initial
    begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout after %0d cycles, the tests did not finish", watchdog_cycles);
        $display("Something failed");
        $finish;
    end

    //--------------------------------------------------
    // random numbers and reference tables

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // segment a in the msb and no dot
    function automatic logic [6:0] hex_segments(logic [3:0] n);
        case (n)
            4'h0: return 7'b1111110;
            4'h1: return 7'b0110000;
            4'h2: return 7'b1101101;
            4'h3: return 7'b1111001;
            4'h4: return 7'b0110011;
            4'h5: return 7'b1011011;
            4'h6: return 7'b1011111;
            4'h7: return 7'b1110000;
            4'h8: return 7'b1111111;
            4'h9: return 7'b1111011;
            4'ha: return 7'b1110111;
            4'hb: return 7'b0011111;
            4'hc: return 7'b1001110;
            4'hd: return 7'b0111101;
            4'he: return 7'b1001111;
            default: return 7'b1000111;
        endcase
    endfunction

    // stretcher output at an offset in cycles from now
    function automatic tube_vec_t expected_ext(int offset);
        tube_vec_t v;
        for (int t = 0; t < `GEIGER_N_TUBES; t++)
            v[t] = (m_age[t] + offset >= 3) && (m_age[t] + offset <= `GEIGER_EXT_CYCLES + 2);
        return v;
    endfunction

    //--------------------------------------------------
    // cycle stepping and stimulus

    task automatic tick();
        @(posedge clk);
        #1;
        for (int t = 0; t < `GEIGER_N_TUBES; t++)
        begin
            if (m_age[t] < 100000)
                m_age[t]++;
        end
    endtask

    task automatic drive_tubes(tube_vec_t v);
        tube_raw = v;
        for (int t = 0; t < `GEIGER_N_TUBES; t++)
        begin
            if (v[t] && !m_prev_raw[t])
            begin
                m_age[t] = 0;
                if (m_enable)
                    m_count = m_count + particle_cnt_t'(1);
            end
            if (v[t] && m_enable)
                m_exposure = m_exposure + exposure_cnt_t'(1);
        end
        m_prev_raw = v;
        tick();
    endtask

    task automatic idle(int n);
        repeat (n) drive_tubes('0);
    endtask

    // every level held at least 3 cycles
    task automatic pulse_train(int n);
        tube_vec_t v;
        int        hold;
        for (int s = 0; s < n; s++)
        begin
            v    = tube_vec_t'(next_random());
            hold = 3 + int'(next_random() % 6);
            repeat (hold) drive_tubes(v);
        end
    endtask

    //--------------------------------------------------
    // APB transfers sampled mid access cycle

    task automatic apb_write(apb_addr_t addr, apb_data_t data, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        tick();
        apb_req.penable = 1'b1;
        #4;
        err = apb_rsp.pslverr;
        tick();
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_read(apb_addr_t addr, output apb_data_t data, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        tick();
        apb_req.penable = 1'b1;
        #4;
        data = apb_rsp.prdata;
        err  = apb_rsp.pslverr;
        tick();
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    //--------------------------------------------------
    // compare tasks

    task automatic check_particle(string name, particle_cnt_t got, particle_cnt_t want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_exposure(string name, exposure_cnt_t got, exposure_cnt_t want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_tubes(string name, tube_vec_t got, tube_vec_t want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_segments(string name, segments_t got, segments_t want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_err(string name, logic got, logic want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, want);
        end
    endtask

    task automatic check_word(string name, apb_data_t got, apb_data_t want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("Fail %s: got %h, expected %h", name, got, want);
        end
    endtask

    //--------------------------------------------------
    // grouped checks

    task automatic read_counters();
        apb_data_t rdata;
        logic      err;
        apb_read(REG_COUNT, rdata, err);
        check_particle("count", particle_cnt_t'(rdata), m_count);
        check_err("pslverr", err, 1'b0);
        apb_read(REG_EXPOSURE, rdata, err);
        check_exposure("exposure", exposure_cnt_t'(rdata), m_exposure);
    endtask

    task automatic read_ctrl(logic want_enable);
        apb_data_t rdata;
        logic      err;
        ctrl_t     ctrl_rd;
        apb_read(REG_CTRL, rdata, err);
        ctrl_rd = ctrl_t'(rdata[$bits(ctrl_t) - 1:0]);
        check_err("pslverr", err, 1'b0);
        check_err("ctrl.enable", ctrl_rd.enable, want_enable);
        check_err("ctrl.clear", ctrl_rd.clear, 1'b0);
    endtask

    task automatic read_status_and_led();
        apb_data_t rdata;
        logic      err;
        tube_vec_t want;
        check_tubes("led", led, expected_ext(0));
        // status is sampled one cycle later
        want = expected_ext(1);
        apb_read(REG_STATUS, rdata, err);
        check_tubes("status", tube_vec_t'(rdata), want);
        check_err("pslverr", err, 1'b0);
    endtask

    // abcdefgh was loaded from the previous cycle's state
    task automatic check_display();
        display_num_t num;
        tube_vec_t    ext_prev;
        int           idx;
        checks++;
        if (!$onehot(digit))
        begin
            errors++;
            $display("digit select is not one-hot: %b", digit);
            return;
        end
        idx = 0;
        for (int i = 0; i < `GEIGER_N_DIGITS; i++)
        begin
            if (digit[i])
                idx = i;
        end
        num      = display_num_t'({m_exposure, m_count});
        ext_prev = expected_ext(-1);
        check_segments("abcdefgh", abcdefgh,
                       {hex_segments(num[4 * idx +: 4]), ext_prev[idx % `GEIGER_N_TUBES]});
    endtask

    task automatic report_test(string name, int errors_before);
        tests_run++;
        if (errors == errors_before)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    //--------------------------------------------------
    // test sequence

    initial
    begin
        apb_data_t  rdata;
        logic       err;
        int         e0;
        digit_sel_t seen;

        rst        = 1'b1;
        tube_raw   = '0;
        apb_req    = '0;
        errors     = 0;
        checks     = 0;
        tests_run  = 0;
        rng_state  = 32'h3580;
        m_count    = '0;
        m_exposure = '0;
        m_enable   = 1'b1;
        m_prev_raw = '0;
        for (int t = 0; t < `GEIGER_N_TUBES; t++)
            m_age[t] = 100000;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        e0 = errors;
        for (int r = 0; r < n_rounds; r++)
        begin
            pulse_train(n_segs);
            idle(settle);
            read_counters();
        end
        report_test("pulse counting", e0);

        // clear, hold while disabled, then resume
        e0 = errors;
        apb_write(REG_CTRL, 32'h3, err);
        m_count    = '0;
        m_exposure = '0;
        read_ctrl(1'b1);
        idle(2);
        read_counters();
        apb_write(REG_CTRL, 32'h0, err);
        m_enable = 1'b0;
        read_ctrl(1'b0);
        pulse_train(n_short);
        idle(settle);
        read_counters();
        apb_write(REG_CTRL, 32'h2, err);
        m_enable = 1'b1;
        read_ctrl(1'b1);
        pulse_train(n_short);
        idle(settle);
        read_counters();
        report_test("clear and enable", e0);

        e0 = errors;
        idle(ext_wait);
        repeat (3) drive_tubes(tube_vec_t'(1));
        idle(settle);
        read_status_and_led();
        idle(ext_wait);
        read_status_and_led();
        report_test("pulse stretch", e0);

        // unmapped offsets and read-only writes
        e0 = errors;
        apb_read(8'h10, rdata, err);
        check_err("pslverr", err, 1'b1);
        check_word("prdata", rdata, '0);
        apb_write(8'h14, 32'h0, err);
        check_err("pslverr", err, 1'b1);
        read_ctrl(1'b1);
        apb_write(REG_COUNT, 32'hffff, err);
        check_err("pslverr", err, 1'b0);
        read_counters();
        report_test("unmapped offset", e0);

        e0 = errors;
        repeat (3) drive_tubes(tube_vec_t'(2));
        idle(settle);
        seen = '0;
        for (int c = 0; c < scan_cycles; c++)
        begin
            tick();
            check_display();
            seen = seen | digit;
        end
        // a full scan fits in the loop
        checks++;
        if (seen !== '1)
        begin
            errors++;
            $display("the scan did not visit every digit: %b", seen);
        end
        report_test("display scan", e0);

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tube_pulse_conditioner.sv ====
`timescale 1ns/1ps
`default_nettype none

module tube_pulse_conditioner
    import geiger_types_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  tube_vec_t tube_raw,
    output tube_vec_t tube_level,
    output tube_vec_t tube_edge
);

    tube_vec_t tube_sync1;
    tube_vec_t tube_level_d;

    //--------------------------------------------------
    // two-flop synchronizer, raw lines are asynchronous

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tube_sync1 <= '0;
            tube_level <= '0;
        end
        else
        begin
            tube_sync1 <= tube_raw;
            tube_level <= tube_sync1;
        end
    end

    //--------------------------------------------------
    // delayed copy for edge detection

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            tube_level_d <= '0;
        else
            tube_level_d <= tube_level;
    end

    // high in the first cycle of a synchronized pulse
    assign tube_edge = tube_level & ~tube_level_d;

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
geiger_types_pkg.sv
geiger_apb_pkg.sv
tube_pulse_conditioner.sv
particle_counter.sv
seven_segment_scan.sv
geiger_apb_regs.sv
geiger_top.sv
geiger_props.sv
tb_geiger.sv
